/* source/etx_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// etx_pkg
// Shared constants for the link transmitter: transaction layout,
// channel numbering, FIFO sizing, host register map and frame shape
// ~~~~~~~~~~~~~~~~~~~~
package etx_pkg;

   // Mesh transaction layout, top down
   localparam int TXN_W         = 103;
   localparam int TXN_WRITE_BIT = 102;            // Write flag
   localparam int TXN_DMODE_LSB = 100;            // Datamode, 2 bits
   localparam int TXN_CMODE_LSB = 96;             // Ctrlmode, 4 bits
   localparam int TXN_DST_LSB   = 64;             // Destination address
   localparam int TXN_DATA_LSB  = 32;             // Data word
   localparam int TXN_SRC_LSB   = 0;              // Source address

   // Channels
   localparam int CH_NUM = 3;
   localparam int CH_WR  = 0;                     // Write
   localparam int CH_RQ  = 1;                     // Read request
   localparam int CH_RR  = 2;                     // Read response

   // Channel FIFO sizing
   localparam int FIFO_DEPTH      = 16;
   localparam int FIFO_AW         = 4;            // Pointer width
   localparam int PROG_FULL_LEVEL = 12;           // Almost-full threshold

   // Host register map, word addresses
   localparam int WB_AW         = 3;
   localparam int REG_DST       = 0;              // Staged dstaddr
   localparam int REG_DATA      = 1;              // Staged data
   localparam int REG_SRC       = 2;              // Staged srcaddr
   localparam int REG_PUSH_BASE = 3;              // Push window, 3..5
   localparam int REG_STATUS    = 7;              // FIFO flags and waits

   // Link frame
   localparam int FRAME_BYTES = 13;               // Header byte plus 3 words
   localparam int SYNC_STAGES = 2;                // Wait synchronizer depth

endpackage

/* source/etx_host_port.sv */
// ~~~~~~~~~~~~~~~~~~~~
// etx_host_port
// Wishbone classic slave for the transmitter. Stages the address and
// data words, pushes a full transaction into one channel FIFO and
// returns the status word on reads
// ~~~~~~~~~~~~~~~~~~~~
module etx_host_port import etx_pkg::*;
(
   input  logic              tx_lclk_p,
   input  logic              arst_n,
   input  logic              wb_cyc,
   input  logic              wb_stb,
   input  logic              wb_we,
   input  logic [WB_AW-1:0]  wb_adr,
   input  logic [31:0]       wb_wdata,
   input  logic [CH_NUM-1:0] fifo_full,
   input  logic [CH_NUM-1:0] fifo_prog_full,
   input  logic [CH_NUM-1:0] fifo_empty,
   input  logic              wr_wait_sync,
   input  logic              rd_wait_sync,
   output logic              wb_ack,
   output logic [31:0]       wb_rdata,
   output logic [CH_NUM-1:0] push,
   output logic [TXN_W-1:0]  push_data
);

   logic              req;                        // New strobe, not yet acked
   logic [CH_NUM-1:0] push_hit;                   // One-hot push target
   logic              push_blk;                   // Target FIFO is full
   logic              take;                       // Cycle acked this edge
   logic [31:0]       dst_q;
   logic [31:0]       data_q;
   logic [31:0]       src_q;
   logic [31:0]       status;
   logic [TXN_W-1:0]  txn_asm;

   assign req = wb_cyc & wb_stb & ~wb_ack;        // ~ack keeps ack one cycle

   always_comb
   begin
      for (int c = 0; c < CH_NUM; c++)
      begin
         push_hit[c] = wb_we && (wb_adr == WB_AW'(REG_PUSH_BASE + c));
      end
   end

   assign push_blk = |(push_hit & fifo_full);     // Hold ack until room
   assign take     = req & ~push_blk;

   // Push word carries the control fields, staging regs the rest
   always_comb
   begin
      txn_asm                        = '0;
      txn_asm[TXN_WRITE_BIT]         = wb_wdata[0];
      txn_asm[TXN_DMODE_LSB +: 2]    = wb_wdata[2:1];
      txn_asm[TXN_CMODE_LSB +: 4]    = wb_wdata[6:3];
      txn_asm[TXN_DST_LSB +: 32]     = dst_q;
      txn_asm[TXN_DATA_LSB +: 32]    = data_q;
      txn_asm[TXN_SRC_LSB +: 32]     = src_q;
   end

   always_ff @(posedge tx_lclk_p or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wb_ack <= 1'b0;
         push   <= '0;
      end
      else
      begin
         wb_ack <= take;
         push   <= take ? push_hit : '0;          // Pulse rides with ack
      end
   end

   // Staging and push payload
   always_ff @(posedge tx_lclk_p)
   begin
      if (take && wb_we && wb_adr == WB_AW'(REG_DST))
         dst_q <= wb_wdata;
      if (take && wb_we && wb_adr == WB_AW'(REG_DATA))
         data_q <= wb_wdata;
      if (take && wb_we && wb_adr == WB_AW'(REG_SRC))
         src_q <= wb_wdata;
      if (take && |push_hit)
         push_data <= txn_asm;                    // Captured with the ack
   end

   assign status = {{(32 - 2 - 3*CH_NUM){1'b0}},
                    rd_wait_sync,                 // Bit 10
                    wr_wait_sync,                 // Bit 9
                    fifo_full,                    // Bits 8:6
                    fifo_prog_full,               // Bits 5:3
                    fifo_empty};                  // Bits 2:0

   always_comb
   begin
      case (wb_adr)
         WB_AW'(REG_DST):    wb_rdata = dst_q;
         WB_AW'(REG_DATA):   wb_rdata = data_q;
         WB_AW'(REG_SRC):    wb_rdata = src_q;
         WB_AW'(REG_STATUS): wb_rdata = status;
         default:            wb_rdata = '0;       // Push window reads zero
      endcase
   end

endmodule

/* source/etx_chan_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~
// etx_chan_fifo
// Show-ahead synchronous FIFO holding transactions for one channel,
// with empty, full and almost-full flags from a fill count
// ~~~~~~~~~~~~~~~~~~~~
module etx_chan_fifo import etx_pkg::*;
(
   input  logic             tx_lclk_p,
   input  logic             arst_n,
   input  logic             push,
   input  logic [TXN_W-1:0] push_data,
   input  logic             pop,
   output logic [TXN_W-1:0] head,
   output logic             empty,
   output logic             full,
   output logic             prog_full
);

   logic [TXN_W-1:0]  mem [FIFO_DEPTH];           // Entry storage
   logic [FIFO_AW-1:0] wr_ptr;
   logic [FIFO_AW-1:0] rd_ptr;
   logic [FIFO_AW:0]   count;                     // 0..FIFO_DEPTH
   logic               do_push;
   logic               do_pop;

   assign do_push = push & ~full;                 // Never overwrite
   assign do_pop  = pop & ~empty;

   always_ff @(posedge tx_lclk_p or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;              // Wraps at depth
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;              // Idle or both
         endcase
      end
   end

   always_ff @(posedge tx_lclk_p)
   begin
      if (do_push)
         mem[wr_ptr] <= push_data;
   end

   // Oldest entry always on the output
   assign head      = mem[rd_ptr];
   assign empty     = (count == '0);
   assign full      = (count == (FIFO_AW+1)'(FIFO_DEPTH));
   assign prog_full = (count >= (FIFO_AW+1)'(PROG_FULL_LEVEL));

endmodule

/* source/etx_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~
// etx_arbiter
// Fixed-priority pick among the channel FIFO heads: read response,
// then write, then read request. A grant is held for the whole frame
// and the FIFO is popped on its last byte
// ~~~~~~~~~~~~~~~~~~~~
module etx_arbiter import etx_pkg::*;
(
   input  logic                    tx_lclk_p,
   input  logic                    arst_n,
   input  logic [CH_NUM*TXN_W-1:0] fifo_head,
   input  logic [CH_NUM-1:0]       fifo_empty,
   input  logic                    wr_wait_sync,
   input  logic                    rd_wait_sync,
   input  logic                    txn_done,
   output logic [CH_NUM-1:0]       pop,
   output logic                    txn_valid,
   output logic [TXN_W-1:0]        txn
);

   logic [CH_NUM-1:0] elig;                       // Ready and not waited
   logic [CH_NUM-1:0] pick;                       // One-hot winner
   logic [CH_NUM-1:0] grant;                      // Held winner
   logic [TXN_W-1:0]  sel_head;

   // Write and read response share the write push-back
   always_comb
   begin
      elig        = '0;
      elig[CH_RR] = ~fifo_empty[CH_RR] & ~wr_wait_sync;
      elig[CH_WR] = ~fifo_empty[CH_WR] & ~wr_wait_sync;
      elig[CH_RQ] = ~fifo_empty[CH_RQ] & ~rd_wait_sync;
   end

   always_comb
   begin
      pick = '0;
      if (elig[CH_RR])
         pick[CH_RR] = 1'b1;                      // Responses first
      else if (elig[CH_WR])
         pick[CH_WR] = 1'b1;
      else if (elig[CH_RQ])
         pick[CH_RQ] = 1'b1;
   end

   always_comb
   begin
      sel_head = '0;
      for (int c = 0; c < CH_NUM; c++)
      begin
         if (pick[c])
            sel_head = fifo_head[c*TXN_W +: TXN_W];
      end
   end

   always_ff @(posedge tx_lclk_p or negedge arst_n)
   begin
      if (!arst_n)
      begin
         txn_valid <= 1'b0;
         grant     <= '0;
      end
      else if (txn_valid)
      begin
         if (txn_done)
         begin
            txn_valid <= 1'b0;                    // Idle cycle before next pick
            grant     <= '0;
         end
      end
      else if (|elig)
      begin
         txn_valid <= 1'b1;                       // Waits checked only here
         grant     <= pick;
      end
   end

   // Payload held stable while the frame runs
   always_ff @(posedge tx_lclk_p)
   begin
      if (!txn_valid && |elig)
         txn <= sel_head;
   end

   assign pop = txn_done ? grant : '0;            // Advances on the done edge

endmodule

/* source/etx_protocol.sv */
// ~~~~~~~~~~~~~~~~~~~~
// etx_protocol
// Synchronizes the far-end wait inputs and serializes one held
// transaction into a 13-byte frame on the 8-bit link bus
// ~~~~~~~~~~~~~~~~~~~~
module etx_protocol import etx_pkg::*;
(
   input  logic             tx_lclk_p,
   input  logic             arst_n,
   input  logic             txn_valid,
   input  logic [TXN_W-1:0] txn,
   input  logic             tx_wr_wait,
   input  logic             tx_rd_wait,
   output logic             txn_done,
   output logic             tx_frame,
   output logic [7:0]       tx_data,
   output logic             wr_wait_sync,
   output logic             rd_wait_sync
);

   logic [SYNC_STAGES-1:0]   wr_sync;             // Write wait flops
   logic [SYNC_STAGES-1:0]   rd_sync;             // Read wait flops
   logic [3:0]               byte_cnt;            // Index of the byte on the bus
   logic [3:0]               nxt_idx;
   logic [FRAME_BYTES*8-1:0] frame_bits;
   logic [7:0]               nxt_byte;
   logic                     last_byte;

   always_ff @(posedge tx_lclk_p or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_sync <= '0;
         rd_sync <= '0;
      end
      else
      begin
         wr_sync <= {wr_sync[SYNC_STAGES-2:0], tx_wr_wait};
         rd_sync <= {rd_sync[SYNC_STAGES-2:0], tx_rd_wait};
      end
   end

   assign wr_wait_sync = wr_sync[SYNC_STAGES-1];
   assign rd_wait_sync = rd_sync[SYNC_STAGES-1];

   // Header byte then dst, data and src words sent MSB first
   assign frame_bits = {txn[TXN_CMODE_LSB +: 4],
                        txn[TXN_DMODE_LSB +: 2],
                        txn[TXN_WRITE_BIT],
                        1'b1,                     // Header marker
                        txn[TXN_DST_LSB +: 32],
                        txn[TXN_DATA_LSB +: 32],
                        txn[TXN_SRC_LSB +: 32]};

   assign last_byte = tx_frame && (byte_cnt == 4'(FRAME_BYTES - 1));
   assign nxt_idx   = (tx_frame && !last_byte) ? byte_cnt + 4'd1 : 4'd0;
   assign nxt_byte  = frame_bits[(FRAME_BYTES - 1 - nxt_idx)*8 +: 8];

   always_ff @(posedge tx_lclk_p or negedge arst_n)
   begin
      if (!arst_n)
      begin
         tx_frame <= 1'b0;
         tx_data  <= '0;
         byte_cnt <= '0;
         txn_done <= 1'b0;
      end
      else
      begin
         txn_done <= tx_frame && (byte_cnt == 4'(FRAME_BYTES - 2));  // With byte 12
         if (!tx_frame)
         begin
            if (txn_valid)
            begin
               tx_frame <= 1'b1;                  // Frame opens with byte 0
               byte_cnt <= '0;
               tx_data  <= nxt_byte;
            end
         end
         else if (last_byte)
         begin
            tx_frame <= 1'b0;
            tx_data  <= '0;                       // Bus quiet between frames
         end
         else
         begin
            byte_cnt <= nxt_idx;
            tx_data  <= nxt_byte;
         end
      end
   end

endmodule

/* source/etx_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// etx_top
// Link transmitter: host port, one FIFO per channel, the priority
// arbiter and the byte framer
// ~~~~~~~~~~~~~~~~~~~~
module etx_top import etx_pkg::*;
(
   input  logic             tx_lclk_p,
   input  logic             arst_n,
   input  logic             wb_cyc,
   input  logic             wb_stb,
   input  logic             wb_we,
   input  logic [WB_AW-1:0] wb_adr,
   input  logic [31:0]      wb_wdata,
   input  logic             tx_wr_wait,
   input  logic             tx_rd_wait,
   output logic             wb_ack,
   output logic [31:0]      wb_rdata,
   output logic             tx_frame,
   output logic [7:0]       tx_data
);

   logic [CH_NUM-1:0]       push;                 // Host to FIFOs
   logic [TXN_W-1:0]        push_data;
   logic [CH_NUM-1:0]       pop;                  // Arbiter to FIFOs
   logic [CH_NUM*TXN_W-1:0] fifo_head;            // Flat head bus
   logic [CH_NUM-1:0]       fifo_empty;
   logic [CH_NUM-1:0]       fifo_full;
   logic [CH_NUM-1:0]       fifo_prog_full;
   logic                    txn_valid;
   logic [TXN_W-1:0]        txn;
   logic                    txn_done;
   logic                    wr_wait_sync;
   logic                    rd_wait_sync;

   etx_host_port u_host (
      .tx_lclk_p      (tx_lclk_p),
      .arst_n         (arst_n),
      .wb_cyc         (wb_cyc),
      .wb_stb         (wb_stb),
      .wb_we          (wb_we),
      .wb_adr         (wb_adr),
      .wb_wdata       (wb_wdata),
      .fifo_full      (fifo_full),
      .fifo_prog_full (fifo_prog_full),
      .fifo_empty     (fifo_empty),
      .wr_wait_sync   (wr_wait_sync),
      .rd_wait_sync   (rd_wait_sync),
      .wb_ack         (wb_ack),
      .wb_rdata       (wb_rdata),
      .push           (push),
      .push_data      (push_data)
   );

   // Write, read request and read response queues
   for (genvar i = 0; i < CH_NUM; i++)
   begin : gen_chan
      etx_chan_fifo u_fifo (
         .tx_lclk_p (tx_lclk_p),
         .arst_n    (arst_n),
         .push      (push[i]),
         .push_data (push_data),
         .pop       (pop[i]),
         .head      (fifo_head[i*TXN_W +: TXN_W]),
         .empty     (fifo_empty[i]),
         .full      (fifo_full[i]),
         .prog_full (fifo_prog_full[i])
      );
   end

   etx_arbiter u_arb (
      .tx_lclk_p    (tx_lclk_p),
      .arst_n       (arst_n),
      .fifo_head    (fifo_head),
      .fifo_empty   (fifo_empty),
      .wr_wait_sync (wr_wait_sync),
      .rd_wait_sync (rd_wait_sync),
      .txn_done     (txn_done),
      .pop          (pop),
      .txn_valid    (txn_valid),
      .txn          (txn)
   );

   etx_protocol u_proto (
      .tx_lclk_p    (tx_lclk_p),
      .arst_n       (arst_n),
      .txn_valid    (txn_valid),
      .txn          (txn),
      .tx_wr_wait   (tx_wr_wait),
      .tx_rd_wait   (tx_rd_wait),
      .txn_done     (txn_done),
      .tx_frame     (tx_frame),
      .tx_data      (tx_data),
      .wr_wait_sync (wr_wait_sync),
      .rd_wait_sync (rd_wait_sync)
   );

endmodule

/* verif/etx_asserts.sv */
// ~~~~~~~~~~~~~~~~~~~~
// etx_asserts
// Checks frame shape, frame gap, header marker, write-wait obedience
// and Wishbone ack release on the transmitter top level
// ~~~~~~~~~~~~~~~~~~~~
module etx_asserts import etx_pkg::*;
(
   input logic              tx_lclk_p,
   input logic              arst_n,
   input logic              tx_frame,
   input logic [7:0]        tx_data,
   input logic              wb_stb,
   input logic              wb_ack,
   input logic              txn_valid,
   input logic [TXN_W-1:0]  txn,
   input logic [CH_NUM-1:0] grant,
   input logic              wr_wait_sync
);

   int         fail_cnt = 0;                      // Read by the testbench
   logic [7:0] run_len;                           // Cycles with tx_frame high
   logic [7:0] idle_len;                          // Saturating idle cycles since last frame
   logic       wr_class;

   assign wr_class = grant[CH_WR] | grant[CH_RR]; // Channels under write wait

   always_ff @(posedge tx_lclk_p or negedge arst_n)
   begin
      if (!arst_n)
      begin
         run_len  <= '0;
         idle_len <= '0;
      end
      else
      begin
         run_len  <= tx_frame ? run_len + 8'd1 : 8'd0;
         if (tx_frame)
            idle_len <= '0;
         else if (idle_len != 8'hFF)
            idle_len <= idle_len + 8'd1;
      end
   end

   frame_len: assert property (@(posedge tx_lclk_p) disable iff (!arst_n)
      $fell(tx_frame) |-> run_len == 8'(FRAME_BYTES))
   else
   begin
      fail_cnt++;
      $error("tx_frame high for %0d cycles", run_len);
   end

   frame_gap: assert property (@(posedge tx_lclk_p) disable iff (!arst_n)
      $rose(tx_frame) |-> idle_len >= 8'd2)
   else
   begin
      fail_cnt++;
      $error("Frames separated by %0d idle cycles", idle_len);
   end

   header_mark: assert property (@(posedge tx_lclk_p) disable iff (!arst_n)
      $rose(tx_frame) |-> tx_data[0])
   else
   begin
      fail_cnt++;
      $error("Header byte without marker bit");
   end

   wait_grant: assert property (@(posedge tx_lclk_p) disable iff (!arst_n)
      $rose(wr_class) |-> !$past(wr_wait_sync))
   else
   begin
      fail_cnt++;
      $error("Write-class grant under write wait");
   end

   wait_write: assert property (@(posedge tx_lclk_p) disable iff (!arst_n)
      $rose(txn_valid) && txn[TXN_WRITE_BIT] |-> !$past(wr_wait_sync))
   else
   begin
      fail_cnt++;
      $error("Write transaction granted under write wait");
   end

   ack_release: assert property (@(posedge tx_lclk_p) disable iff (!arst_n)
      $fell(wb_stb) |-> !wb_ack)
   else
   begin
      fail_cnt++;
      $error("wb_ack still high after stb dropped");
   end

endmodule

/* verif/etx_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// etx_tb
// Testbench for the link transmitter: Wishbone pushes, wait pulses,
// frame scoreboard per channel and a cycle-limit watchdog
// ~~~~~~~~~~~~~~~~~~~~
module etx_tb import etx_pkg::*;
();

   localparam int N_TXN    = 85;                  // 1 + 3 + 4 + 17 + 60
   localparam int HOLD_CYC = 500;                 // Wait holds plus random pulses
   localparam int LIMIT    = 40*N_TXN + HOLD_CYC + 500;

   logic             tx_lclk_p = 1'b0;
   logic             arst_n;
   logic             wb_cyc;
   logic             wb_stb;
   logic             wb_we;
   logic [WB_AW-1:0] wb_adr;
   logic [31:0]      wb_wdata;
   logic             tx_wr_wait;
   logic             tx_rd_wait;
   logic             wb_ack;
   logic [31:0]      wb_rdata;
   logic             tx_frame;
   logic [7:0]       tx_data;

   logic [TXN_W-1:0]         exp_q [CH_NUM][$];   // Expected, per channel
   int                       sent_ch[$];          // Channel of each matched frame
   logic [FRAME_BYTES*8-1:0] fbytes;
   int                       nbytes = 0;
   int                       err_cnt = 0;
   int                       cycle = 0;
   logic [15:0]              lfsr = 16'd27;
   logic                     no_frame_window = 1'b0;
   logic                     late_push_done = 1'b0;

   always #5 tx_lclk_p = ~tx_lclk_p;

   etx_top UUT (.*);

   bind etx_top etx_asserts u_asserts (
      .tx_lclk_p    (tx_lclk_p),
      .arst_n       (arst_n),
      .tx_frame     (tx_frame),
      .tx_data      (tx_data),
      .wb_stb       (wb_stb),
      .wb_ack       (wb_ack),
      .txn_valid    (txn_valid),
      .txn          (txn),
      .grant        (u_arb.grant),
      .wr_wait_sync (wr_wait_sync)
   );

   // Galois LFSR, one step per bit
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      end
      return v;
   endfunction

   task automatic wb_access(input logic we, input logic [WB_AW-1:0] adr,
                            input logic [31:0] wdat, output logic [31:0] rdat);
      @(posedge tx_lclk_p);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= adr;
      wb_wdata <= wdat;
      do
         @(posedge tx_lclk_p);
      while (!wb_ack);                            // Stalls while FIFO full
      rdat = wb_rdata;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   // Stage dst, data, src, then push; write flag follows the channel
   task automatic push_txn(input int ch);
      logic [31:0] dst;
      logic [31:0] dat;
      logic [31:0] src;
      logic [31:0] ctl;
      logic [31:0] rd;
      dst = lfsr_bits(32);
      dat = lfsr_bits(32);
      src = lfsr_bits(32);
      ctl = lfsr_bits(6);                         // Datamode 1:0, ctrlmode 5:2
      wb_access(1'b1, WB_AW'(REG_DST), dst, rd);
      wb_access(1'b1, WB_AW'(REG_DATA), dat, rd);
      wb_access(1'b1, WB_AW'(REG_SRC), src, rd);
      wb_access(1'b1, WB_AW'(REG_PUSH_BASE + ch),
                {25'd0, ctl[5:2], ctl[1:0], ch == CH_WR}, rd);
      exp_q[ch].push_back({ch == CH_WR, ctl[1:0], ctl[5:2], dst, dat, src});
   endtask

   task automatic expect_status(input logic [31:0] mask, input logic [31:0] val);
      logic [31:0] rd;
      wb_access(1'b0, WB_AW'(REG_STATUS), 32'd0, rd);
      assert ((rd & mask) == val)
      else
      begin
         err_cnt++;
         $display("Error at %0t: wb_rdata expected %h got %h", $time, val, rd & mask);
      end
   endtask

   task automatic drain_queues();
      while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() != 0)
         @(posedge tx_lclk_p);
      repeat (4) @(posedge tx_lclk_p);
   endtask

   // A frame must equal the oldest entry of exactly one channel
   task automatic match_frame(input logic [TXN_W-1:0] got);
      int hit;
      hit = -1;
      for (int c = 0; c < CH_NUM; c++)
         if (exp_q[c].size() > 0 && exp_q[c][0] == got)
            hit = c;
      assert (hit >= 0)
      else
      begin
         err_cnt++;
         $display("Frame at %0t matches no queue head, out of order or unknown: %h",
                  $time, got);
      end
      if (hit >= 0)
      begin
         void'(exp_q[hit].pop_front());
         sent_ch.push_back(hit);
      end
   endtask

   // Frame monitor, bytes sampled before the edge
   always @(posedge tx_lclk_p)
   begin
      if (!arst_n)
         nbytes = 0;
      else if (tx_frame)
      begin
         assert (!no_frame_window)
         else
         begin
            err_cnt++;
            $display("Frame started at %0t while both waits were held", $time);
         end
         fbytes = {fbytes[FRAME_BYTES*8-9:0], tx_data};
         nbytes++;
         if (nbytes == FRAME_BYTES)
         begin
            match_frame({fbytes[97], fbytes[99:98], fbytes[103:100], fbytes[95:0]});
            nbytes = 0;
         end
      end
   end

   always @(posedge tx_lclk_p)
   begin
      cycle++;
      if (cycle >= LIMIT)
      begin
         $display("Timeout: run still busy after %0d cycles", LIMIT);
         $display("Test failures found");
         $finish;
      end
   end

   initial
   begin
      arst_n     <= 1'b0;
      wb_cyc     <= 1'b0;
      wb_stb     <= 1'b0;
      wb_we      <= 1'b0;
      wb_adr     <= '0;
      wb_wdata   <= '0;
      tx_wr_wait <= 1'b0;
      tx_rd_wait <= 1'b0;
      repeat (10) @(posedge tx_lclk_p);
      arst_n <= 1'b1;
      @(posedge tx_lclk_p);
      assert (!tx_frame)
      else
      begin
         err_cnt++;
         $display("Error at %0t: tx_frame expected 0 got %b", $time, tx_frame);
      end
      expect_status(32'hFFFF_FFFF, 32'h0000_0007);  // All empty, rest clear
      push_txn(CH_WR);
      drain_queues();

      // Priority after a full hold
      tx_wr_wait <= 1'b1;
      tx_rd_wait <= 1'b1;
      repeat (3) @(posedge tx_lclk_p);
      no_frame_window = 1'b1;
      push_txn(CH_WR);
      push_txn(CH_RQ);
      push_txn(CH_RR);
      repeat (20) @(posedge tx_lclk_p);
      sent_ch.delete();
      no_frame_window = 1'b0;
      tx_wr_wait <= 1'b0;
      tx_rd_wait <= 1'b0;
      drain_queues();
      assert (sent_ch.size() == 3 && sent_ch[0] == CH_RR && sent_ch[1] == CH_WR &&
              sent_ch[2] == CH_RQ)
      else
      begin
         err_cnt++;
         $display("Release order at %0t is not read response, write, read request", $time);
      end

      // Only the write wait held
      tx_wr_wait <= 1'b1;
      repeat (3) @(posedge tx_lclk_p);
      push_txn(CH_WR);
      push_txn(CH_RR);
      push_txn(CH_RQ);
      push_txn(CH_RQ);
      while (exp_q[CH_RQ].size() != 0)
         @(posedge tx_lclk_p);
      repeat (20) @(posedge tx_lclk_p);
      assert (exp_q[CH_WR].size() == 1 && exp_q[CH_RR].size() == 1)
      else
      begin
         err_cnt++;
         $display("Write wait at %0t did not hold write and read response", $time);
      end
      tx_wr_wait <= 1'b0;
      drain_queues();

      // Fill the write FIFO against the wait
      tx_wr_wait <= 1'b1;
      repeat (3) @(posedge tx_lclk_p);
      for (int i = 1; i <= FIFO_DEPTH; i++)
      begin
         push_txn(CH_WR);
         if (i == PROG_FULL_LEVEL)
            expect_status(32'h0000_0008, 32'h0000_0008);   // Write prog_full
      end
      expect_status(32'h0000_0040, 32'h0000_0040);         // Write full
      fork
         begin
            push_txn(CH_WR);
            late_push_done = 1'b1;
         end
      join_none
      repeat (40) @(posedge tx_lclk_p);
      assert (exp_q[CH_WR].size() == FIFO_DEPTH)
      else
      begin
         err_cnt++;
         $display("Push into a full FIFO was acked at %0t", $time);
      end
      tx_wr_wait <= 1'b0;
      wait (late_push_done);
      drain_queues();

      // Random channels with short wait pulses
      for (int n = 0; n < 60; n++)
      begin
         logic [31:0] r;
         r = lfsr_bits(2);
         tx_wr_wait <= r[0];
         tx_rd_wait <= r[1];
         repeat (lfsr_bits(3)) @(posedge tx_lclk_p);
         tx_wr_wait <= 1'b0;
         tx_rd_wait <= 1'b0;
         push_txn(int'(lfsr_bits(2) % 3));
      end
      drain_queues();

      $display("Check errors: %0d, assertion failures: %0d", err_cnt,
               UUT.u_asserts.fail_cnt);
      if (err_cnt == 0 && UUT.u_asserts.fail_cnt == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

/* build.f */
source/etx_pkg.sv
source/etx_host_port.sv
source/etx_chan_fifo.sv
source/etx_arbiter.sv
source/etx_protocol.sv
source/etx_top.sv
verif/etx_asserts.sv
verif/etx_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the link transmitter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module etx_tb -o etx_sim \
   > compile.log 2>&1
if [ $? -ne 0 ]; then
   echo "Compile failed, see compile.log"
   exit 1
fi

./obj_dir/etx_sim +verilator+error+limit+1000 > sim.log 2>&1
if [ $? -ne 0 ]; then
   echo "Simulation exited with an error, see sim.log"
   exit 1
fi

if grep -q 'All tests passed!' sim.log; then
   echo "PASS"
   exit 0
fi
echo "FAIL, see sim.log"
exit 1
